// ==== source/game_params.svh ====
`ifndef GAME_PARAMS_SVH
`define GAME_PARAMS_SVH

// map object counts
`define N_BLOCKS        8
`define N_FLAKES        4
`define N_MONSTERS      2

// box sizes in pixels
`define PLAYER_W        16
`define PLAYER_H        16
`define BLOCK_W         24
`define BLOCK_H         8
`define ITEM_W          8
`define ITEM_H          8

// spawn point and jump height
`define START_X         0
`define START_Y         100
`define JUMP_RISE       20
`define START_HEALTH    3

// wishbone word addresses
`define REG_KEYS        0
`define REG_POS_X       1
`define REG_POS_Y       2
`define REG_STATUS      3
`define REG_ICE         4

`endif

// ==== source/game_pkg.sv ====
`include "game_params.svh"

package game_pkg;

    typedef logic [9:0]             coord_x_t;
    typedef logic [8:0]             coord_y_t;
    typedef logic [`N_BLOCKS-1:0]   block_mask_t;
    typedef logic [`N_FLAKES-1:0]   flake_mask_t;
    typedef logic [3:0]             score_t;
    typedef logic [3:0]             health_t;
    typedef logic [3:0]             contact_t;

    // bit positions inside contact_t
    localparam int CT_FLOOR = 0;
    localparam int CT_CEIL  = 1;
    localparam int CT_LEFT  = 2;
    localparam int CT_RIGHT = 3;

    typedef enum logic [1:0] {
        V_GROUND = 2'd0,
        V_RISE   = 2'd1,
        V_FALL   = 2'd2
    } vert_state_e;

    typedef enum logic [1:0] {
        G_PLAYING = 2'd0,
        G_WON     = 2'd1,
        G_LOST    = 2'd2
    } game_state_e;

    // true when [a, a+a_len) and [b, b+b_len) share a pixel
    function automatic logic span_overlap(input int a, input int a_len,
                                          input int b, input int b_len);
        return (a < b + b_len) && (a + a_len > b);
    endfunction

    // six floor blocks, then a step and a floating ledge
    function automatic coord_x_t block_x(input int idx);
        if (idx < 6) begin
            return coord_x_t'(24 * idx);
        end
        return (idx == 6) ? coord_x_t'(144) : coord_x_t'(104);
    endfunction

    function automatic coord_y_t block_y(input int idx);
        if (idx < 6) begin
            return coord_y_t'(200);
        end
        return (idx == 6) ? coord_y_t'(184) : coord_y_t'(164);
    endfunction

    function automatic coord_x_t flake_x(input int idx);
        case (idx)
            0:       return coord_x_t'(30);
            1:       return coord_x_t'(80);
            2:       return coord_x_t'(150);
            default: return coord_x_t'(110);
        endcase
    endfunction

    function automatic coord_y_t flake_y(input int idx);
        case (idx)
            0:       return coord_y_t'(188);
            1:       return coord_y_t'(188);
            2:       return coord_y_t'(172);
            default: return coord_y_t'(150);
        endcase
    endfunction

    // one monster on the floor, one beside the step
    function automatic coord_x_t monster_x(input int idx);
        return (idx == 0) ? coord_x_t'(60) : coord_x_t'(136);
    endfunction

    function automatic coord_y_t monster_y(input int idx);
        return (idx == 0) ? coord_y_t'(190) : coord_y_t'(176);
    endfunction

endpackage

// ==== source/wb_regs.sv ====
`timescale 1ns/100ps
`include "game_params.svh"

module wb_regs (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     wb_cyc_i,
    input  logic                     wb_stb_i,
    input  logic                     wb_we_i,
    input  logic [2:0]               wb_adr_i,
    input  logic [7:0]               wb_dat_i,
    output logic [15:0]              wb_dat_o,
    output logic                     wb_ack_o,
    output logic [2:0]               keys_o,
    output logic                     restart_o,
    input  game_pkg::coord_x_t       pos_x_i,
    input  game_pkg::coord_y_t       pos_y_i,
    input  game_pkg::score_t         score_i,
    input  game_pkg::health_t        health_i,
    input  game_pkg::game_state_e    state_i,
    input  game_pkg::block_mask_t    ice_i
);

    logic        req;
    logic        wr_keys;
    logic [15:0] rd_word;

    // new request, not yet acknowledged
    assign req     = wb_cyc_i & wb_stb_i & ~wb_ack_o;
    assign wr_keys = req & wb_we_i & (wb_adr_i == 3'(`REG_KEYS));

    // restart is a strobe only, lined up with the ack edge
    assign restart_o = wr_keys & wb_dat_i[3];

    always_comb begin
        case (wb_adr_i)
            `REG_KEYS:   rd_word = 16'(keys_o);
            `REG_POS_X:  rd_word = 16'(pos_x_i);
            `REG_POS_Y:  rd_word = 16'(pos_y_i);
            `REG_STATUS: rd_word = 16'({state_i, health_i, score_i});
            `REG_ICE:    rd_word = 16'(ice_i);
            default:     rd_word = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_ack_o <= 1'b0;
            keys_o   <= '0;
        end else begin
            wb_ack_o <= req;
            if (wr_keys) begin
                keys_o <= wb_dat_i[2:0];
            end
        end
    end

    // read word captured with the request, held through ack
    always_ff @(posedge clk) begin
        if (req) begin
            wb_dat_o <= rd_word;
        end
    end

    a_ack_single : assert property (
        @(posedge clk) disable iff (!rst_n_i) wb_ack_o |=> !wb_ack_o
    );

endmodule

// ==== source/block_collide.sv ====
`timescale 1ns/100ps
`include "game_params.svh"

module block_collide (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  game_pkg::coord_x_t       pos_x_i,
    input  game_pkg::coord_y_t       pos_y_i,
    output game_pkg::contact_t       contact_o,
    output game_pkg::block_mask_t    floor_mask_o
);

    // right edge of the play field, end of the step block
    localparam int FIELD_RIGHT = 168;

    game_pkg::contact_t    contact_d;
    game_pkg::block_mask_t floor_d;

    always_comb begin
        int   px;
        int   py;
        int   bx;
        int   by;
        logic h_ovl;
        logic v_ovl;

        px = int'(pos_x_i);
        py = int'(pos_y_i);
        floor_d = '0;
        contact_d = '0;
        // screen edges act as walls
        contact_d[game_pkg::CT_LEFT]  = (px == 0);
        contact_d[game_pkg::CT_RIGHT] = (px + `PLAYER_W == FIELD_RIGHT);

        for (int i = 0; i < `N_BLOCKS; i++) begin
            bx = int'(game_pkg::block_x(i));
            by = int'(game_pkg::block_y(i));
            h_ovl = game_pkg::span_overlap(px, `PLAYER_W, bx, `BLOCK_W);
            v_ovl = game_pkg::span_overlap(py, `PLAYER_H, by, `BLOCK_H);

            floor_d[i] = h_ovl && (py + `PLAYER_H == by);
            if (floor_d[i]) begin
                contact_d[game_pkg::CT_FLOOR] = 1'b1;
            end
            if (h_ovl && (py == by + `BLOCK_H)) begin
                contact_d[game_pkg::CT_CEIL] = 1'b1;
            end
            // player's left side against the block's right side
            if (v_ovl && (px == bx + `BLOCK_W)) begin
                contact_d[game_pkg::CT_LEFT] = 1'b1;
            end
            if (v_ovl && (px + `PLAYER_W == bx)) begin
                contact_d[game_pkg::CT_RIGHT] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            contact_o    <= '0;
            floor_mask_o <= '0;
        end else begin
            contact_o    <= contact_d;
            floor_mask_o <= floor_d;
        end
    end

endmodule

// ==== source/player_motion.sv ====
`timescale 1ns/100ps
`include "game_params.svh"

module player_motion (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     frame_i,
    input  logic [2:0]               keys_i,
    input  logic                     restart_i,
    input  game_pkg::contact_t       contact_i,
    input  game_pkg::game_state_e    state_i,
    output game_pkg::coord_x_t       pos_x_o,
    output game_pkg::coord_y_t       pos_y_o
);

    localparam int K_LEFT  = 0;
    localparam int K_RIGHT = 1;
    localparam int K_JUMP  = 2;

    logic                  step_q;
    logic [4:0]            rise_q;
    game_pkg::vert_state_e vstate_q;
    logic                  move_left;
    logic                  move_right;
    logic                  on_floor;

    assign move_left  = keys_i[K_LEFT] & ~keys_i[K_RIGHT] & ~contact_i[game_pkg::CT_LEFT];
    assign move_right = keys_i[K_RIGHT] & ~contact_i[game_pkg::CT_RIGHT];
    assign on_floor   = contact_i[game_pkg::CT_FLOOR];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            step_q   <= 1'b0;
            pos_x_o  <= game_pkg::coord_x_t'(`START_X);
            pos_y_o  <= game_pkg::coord_y_t'(`START_Y);
            vstate_q <= game_pkg::V_FALL;
            rise_q   <= '0;
        end else begin
            step_q <= frame_i;
            if (restart_i) begin
                // back to spawn, dropping in
                pos_x_o  <= game_pkg::coord_x_t'(`START_X);
                pos_y_o  <= game_pkg::coord_y_t'(`START_Y);
                vstate_q <= game_pkg::V_FALL;
                rise_q   <= '0;
            end else if (step_q && state_i == game_pkg::G_PLAYING) begin
                if (move_left) begin
                    pos_x_o <= pos_x_o - 1'b1;
                end else if (move_right) begin
                    pos_x_o <= pos_x_o + 1'b1;
                end

                case (vstate_q)
                    game_pkg::V_GROUND: begin
                        if (!on_floor) begin
                            vstate_q <= game_pkg::V_FALL;
                        end else if (keys_i[K_JUMP]) begin
                            vstate_q <= game_pkg::V_RISE;
                            rise_q   <= '0;
                        end
                    end
                    game_pkg::V_RISE: begin
                        // head bump or full height ends the climb
                        if (contact_i[game_pkg::CT_CEIL] || rise_q == 5'(`JUMP_RISE)) begin
                            vstate_q <= game_pkg::V_FALL;
                        end else begin
                            pos_y_o <= pos_y_o - 1'b1;
                            rise_q  <= rise_q + 1'b1;
                        end
                    end
                    default: begin
                        if (on_floor) begin
                            vstate_q <= game_pkg::V_GROUND;
                        end else begin
                            pos_y_o <= pos_y_o + 1'b1;
                        end
                    end
                endcase
            end
        end
    end

    a_vstate_legal : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        vstate_q inside {game_pkg::V_GROUND, game_pkg::V_RISE, game_pkg::V_FALL}
    );

endmodule

// ==== source/pickup_tracker.sv ====
`timescale 1ns/100ps
`include "game_params.svh"

module pickup_tracker (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     restart_i,
    input  game_pkg::coord_x_t       pos_x_i,
    input  game_pkg::coord_y_t       pos_y_i,
    output game_pkg::score_t         score_o,
    output game_pkg::health_t        health_o
);

    game_pkg::flake_mask_t   flake_hit;
    game_pkg::flake_mask_t   collected_q;
    game_pkg::flake_mask_t   new_flakes;
    logic [`N_MONSTERS-1:0]  mon_hit;
    logic [`N_MONSTERS-1:0]  mon_hit_q;
    logic                    mon_entry;

    always_comb begin
        int px;
        int py;

        px = int'(pos_x_i);
        py = int'(pos_y_i);
        for (int i = 0; i < `N_FLAKES; i++) begin
            flake_hit[i] =
                game_pkg::span_overlap(px, `PLAYER_W, int'(game_pkg::flake_x(i)), `ITEM_W) &&
                game_pkg::span_overlap(py, `PLAYER_H, int'(game_pkg::flake_y(i)), `ITEM_H);
        end
        for (int i = 0; i < `N_MONSTERS; i++) begin
            mon_hit[i] =
                game_pkg::span_overlap(px, `PLAYER_W, int'(game_pkg::monster_x(i)), `ITEM_W) &&
                game_pkg::span_overlap(py, `PLAYER_H, int'(game_pkg::monster_y(i)), `ITEM_H);
        end
    end

    // each flake counts only the first time it is touched
    assign new_flakes = flake_hit & ~collected_q;
    // damage on the rising edge of any monster overlap
    assign mon_entry  = |(mon_hit & ~mon_hit_q);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            collected_q <= '0;
            score_o     <= '0;
            mon_hit_q   <= '0;
            health_o    <= game_pkg::health_t'(`START_HEALTH);
        end else if (restart_i) begin
            collected_q <= '0;
            score_o     <= '0;
            mon_hit_q   <= '0;
            health_o    <= game_pkg::health_t'(`START_HEALTH);
        end else begin
            collected_q <= collected_q | flake_hit;
            score_o     <= score_o + game_pkg::score_t'($countones(new_flakes));
            mon_hit_q   <= mon_hit;
            if (mon_entry && health_o != '0) begin
                health_o <= health_o - 1'b1;
            end
        end
    end

    a_score_bound : assert property (
        @(posedge clk) disable iff (!rst_n_i) score_o <= game_pkg::score_t'(`N_FLAKES)
    );

endmodule

// ==== source/stage_fsm.sv ====
`timescale 1ns/100ps

module stage_fsm (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     restart_i,
    input  game_pkg::block_mask_t    floor_mask_i,
    input  game_pkg::health_t        health_i,
    output game_pkg::game_state_e    state_o,
    output game_pkg::block_mask_t    ice_o
);

    game_pkg::block_mask_t ice_d;
    logic                  restart_q;

    // floor mask still shows the pre-restart spot for one cycle
    assign ice_d = restart_q ? ice_o : (ice_o | floor_mask_i);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            restart_q <= 1'b0;
            ice_o     <= '0;
            state_o   <= game_pkg::G_PLAYING;
        end else begin
            restart_q <= restart_i;
            if (restart_i) begin
                ice_o   <= '0;
                state_o <= game_pkg::G_PLAYING;
            end else begin
                ice_o <= ice_d;
                // end states hold until restart
                if (state_o == game_pkg::G_PLAYING) begin
                    if (health_i == '0) begin
                        state_o <= game_pkg::G_LOST;
                    end else if (&ice_d) begin
                        state_o <= game_pkg::G_WON;
                    end
                end
            end
        end
    end

endmodule

// ==== source/game_top.sv ====
`timescale 1ns/100ps

module game_top (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        frame_i,
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic        wb_we_i,
    input  logic [2:0]  wb_adr_i,
    input  logic [7:0]  wb_dat_i,
    output logic [15:0] wb_dat_o,
    output logic        wb_ack_o
);

    logic [2:0]            keys;
    logic                  restart;
    game_pkg::coord_x_t    pos_x;
    game_pkg::coord_y_t    pos_y;
    game_pkg::contact_t    contact;
    game_pkg::block_mask_t floor_mask;
    game_pkg::score_t      score;
    game_pkg::health_t     health;
    game_pkg::game_state_e game_state;
    game_pkg::block_mask_t ice;

    wb_regs i_wb_regs (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .wb_adr_i     (wb_adr_i),
        .wb_dat_i     (wb_dat_i),
        .wb_dat_o     (wb_dat_o),
        .wb_ack_o     (wb_ack_o),
        .keys_o       (keys),
        .restart_o    (restart),
        .pos_x_i      (pos_x),
        .pos_y_i      (pos_y),
        .score_i      (score),
        .health_i     (health),
        .state_i      (game_state),
        .ice_i        (ice)
    );

    block_collide i_block_collide (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .pos_x_i      (pos_x),
        .pos_y_i      (pos_y),
        .contact_o    (contact),
        .floor_mask_o (floor_mask)
    );

    player_motion i_player_motion (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .frame_i      (frame_i),
        .keys_i       (keys),
        .restart_i    (restart),
        .contact_i    (contact),
        .state_i      (game_state),
        .pos_x_o      (pos_x),
        .pos_y_o      (pos_y)
    );

    pickup_tracker i_pickup_tracker (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .restart_i    (restart),
        .pos_x_i      (pos_x),
        .pos_y_i      (pos_y),
        .score_o      (score),
        .health_o     (health)
    );

    stage_fsm i_stage_fsm (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .restart_i    (restart),
        .floor_mask_i (floor_mask),
        .health_i     (health),
        .state_o      (game_state),
        .ice_o        (ice)
    );

endmodule

// ==== bench/clk_gen.sv ====
`timescale 1ns/100ps

module clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o   = 1'b0;
        rst_n_o = 1'b0;
        // hold reset over two rising edges
        repeat (2) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

    always #50 clk_o = ~clk_o;

endmodule

// ==== bench/tb_game.sv ====
`timescale 1ns/100ps
`include "game_params.svh"

module tb_game;

    localparam int N_FRAMES     = 400;
    // frame pulse and settle, one key write and four reads of two cycles each
    localparam int FRAME_CYCLES = 4 + 5 * 2;
    localparam int MAX_CYCLES   = FRAME_CYCLES * N_FRAMES + 2000;
    // right wall of the field sits at the end of the step block
    localparam int FIELD_RIGHT  = 168;

    logic        clk;
    logic        rst_n_i;
    logic        frame_i;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    logic [2:0]  wb_adr_i;
    logic [7:0]  wb_dat_i;
    logic [15:0] wb_dat_o;
    logic        wb_ack_o;

    integer seed = 32'h5d5;
    int     cycles = 0;

    // reference model state
    game_pkg::coord_x_t     mx;
    game_pkg::coord_y_t     my;
    game_pkg::vert_state_e  mv;
    int                     mrise;
    game_pkg::score_t       mscore;
    game_pkg::health_t      mhealth;
    game_pkg::flake_mask_t  mcollected;
    logic [`N_MONSTERS-1:0] mmon;
    game_pkg::block_mask_t  mice;
    game_pkg::game_state_e  mstate;
    logic [2:0]             mkeys;

    clk_gen i_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n_i)
    );

    game_top i_game_top (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .frame_i  (frame_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: run exceeded %0d cycles", MAX_CYCLES);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    function automatic logic spans_meet(input int a, input int al, input int b, input int bl);
        return (a < b + bl) && (b < a + al);
    endfunction

    function automatic game_pkg::contact_t contact_at(input game_pkg::coord_x_t x,
                                                      input game_pkg::coord_y_t y);
        int px;
        int py;
        int bx;
        int by;
        logic hov;
        logic vov;
        game_pkg::contact_t c;
        px = int'(x);
        py = int'(y);
        c = '0;
        c[2] = (px == 0);
        c[3] = (px + `PLAYER_W == FIELD_RIGHT);
        for (int i = 0; i < `N_BLOCKS; i++) begin
            bx = int'(game_pkg::block_x(i));
            by = int'(game_pkg::block_y(i));
            hov = spans_meet(px, `PLAYER_W, bx, `BLOCK_W);
            vov = spans_meet(py, `PLAYER_H, by, `BLOCK_H);
            if (hov && py + `PLAYER_H == by) c[0] = 1'b1;
            if (hov && py == by + `BLOCK_H) c[1] = 1'b1;
            if (vov && px == bx + `BLOCK_W) c[2] = 1'b1;
            if (vov && px + `PLAYER_W == bx) c[3] = 1'b1;
        end
        return c;
    endfunction

    function automatic game_pkg::block_mask_t blocks_under(input game_pkg::coord_x_t x,
                                                          input game_pkg::coord_y_t y);
        game_pkg::block_mask_t m;
        m = '0;
        for (int i = 0; i < `N_BLOCKS; i++) begin
            m[i] = spans_meet(int'(x), `PLAYER_W, int'(game_pkg::block_x(i)), `BLOCK_W)
                && (int'(y) + `PLAYER_H == int'(game_pkg::block_y(i)));
        end
        return m;
    endfunction

    task automatic model_reset();
        mx = game_pkg::coord_x_t'(`START_X);
        my = game_pkg::coord_y_t'(`START_Y);
        mv = game_pkg::V_FALL;
        mrise = 0;
        mscore = '0;
        mhealth = game_pkg::health_t'(`START_HEALTH);
        mcollected = '0;
        mmon = '0;
        mice = '0;
        mstate = game_pkg::G_PLAYING;
    endtask

    task automatic model_frame();
        game_pkg::contact_t    c;
        game_pkg::flake_mask_t fh;
        logic [`N_MONSTERS-1:0] mh;
        if (mstate == game_pkg::G_PLAYING) begin
            c = contact_at(mx, my);
            if (mkeys[0] && !mkeys[1] && !c[2]) begin
                mx = mx - game_pkg::coord_x_t'(1);
            end else if (mkeys[1] && !c[3]) begin
                mx = mx + game_pkg::coord_x_t'(1);
            end
            case (mv)
                game_pkg::V_GROUND: begin
                    if (!c[0]) begin
                        mv = game_pkg::V_FALL;
                    end else if (mkeys[2]) begin
                        mv = game_pkg::V_RISE;
                        mrise = 0;
                    end
                end
                game_pkg::V_RISE: begin
                    if (c[1] || mrise == `JUMP_RISE) begin
                        mv = game_pkg::V_FALL;
                    end else begin
                        my = my - game_pkg::coord_y_t'(1);
                        mrise++;
                    end
                end
                default: begin
                    if (c[0]) mv = game_pkg::V_GROUND;
                    else my = my + game_pkg::coord_y_t'(1);
                end
            endcase
        end
        for (int i = 0; i < `N_FLAKES; i++) begin
            fh[i] = spans_meet(int'(mx), `PLAYER_W, int'(game_pkg::flake_x(i)), `ITEM_W)
                 && spans_meet(int'(my), `PLAYER_H, int'(game_pkg::flake_y(i)), `ITEM_H);
        end
        for (int i = 0; i < `N_MONSTERS; i++) begin
            mh[i] = spans_meet(int'(mx), `PLAYER_W, int'(game_pkg::monster_x(i)), `ITEM_W)
                 && spans_meet(int'(my), `PLAYER_H, int'(game_pkg::monster_y(i)), `ITEM_H);
        end
        mscore = mscore + game_pkg::score_t'($countones(fh & ~mcollected));
        mcollected = mcollected | fh;
        if ((mh & ~mmon) != '0 && mhealth != '0) mhealth = mhealth - 4'd1;
        mmon = mh;
        mice = mice | blocks_under(mx, my);
        if (mstate == game_pkg::G_PLAYING) begin
            if (mhealth == '0) mstate = game_pkg::G_LOST;
            else if (&mice) mstate = game_pkg::G_WON;
        end
    endtask

    task automatic check_pos(input game_pkg::coord_x_t ex, input game_pkg::coord_y_t ey,
                             input game_pkg::coord_x_t gx, input game_pkg::coord_y_t gy);
        if (gx !== ex || gy !== ey) begin
            $display("MISMATCH t=%0t position got (%0d,%0d) expected (%0d,%0d)",
                     $time, gx, gy, ex, ey);
            stop_run("position differs from model");
        end
    endtask

    task automatic check_status(input game_pkg::score_t es, input game_pkg::health_t eh,
                                input game_pkg::game_state_e eg,
                                input game_pkg::score_t gs, input game_pkg::health_t gh,
                                input game_pkg::game_state_e gg);
        if (gs !== es || gh !== eh || gg !== eg) begin
            $display("MISMATCH t=%0t status got s=%0d h=%0d g=%0d expected s=%0d h=%0d g=%0d",
                     $time, gs, gh, gg, es, eh, eg);
            stop_run("status differs from model");
        end
    endtask

    task automatic check_ice(input game_pkg::block_mask_t ei, input game_pkg::block_mask_t gi);
        if (gi !== ei) begin
            $display("MISMATCH t=%0t ice got %b expected %b", $time, gi, ei);
            stop_run("ice mask differs from model");
        end
    endtask

    // one bus cycle, entered and left on a falling edge
    task automatic wb_access(input logic we, input logic [2:0] adr, input logic [7:0] dat,
                             output logic [15:0] rdata);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = dat;
        @(negedge clk);
        if (wb_ack_o !== 1'b1) stop_run("no ack one cycle after the request");
        rdata = wb_dat_o;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        @(negedge clk);
        if (wb_ack_o !== 1'b0) stop_run("ack stayed high for a second cycle");
    endtask

    task automatic write_keys(input logic [3:0] k);
        logic [15:0] unused;
        wb_access(1'b1, 3'(`REG_KEYS), {4'b0, k}, unused);
        mkeys = k[2:0];
        if (k[3]) model_reset();
    endtask

    task automatic check_all();
        logic [15:0] wx;
        logic [15:0] wy;
        logic [15:0] ws;
        logic [15:0] wi;
        wb_access(1'b0, 3'(`REG_POS_X), 8'h00, wx);
        wb_access(1'b0, 3'(`REG_POS_Y), 8'h00, wy);
        wb_access(1'b0, 3'(`REG_STATUS), 8'h00, ws);
        wb_access(1'b0, 3'(`REG_ICE), 8'h00, wi);
        check_pos(mx, my, wx[9:0], wy[8:0]);
        check_status(mscore, mhealth, mstate, ws[3:0], ws[7:4], game_pkg::game_state_e'(ws[9:8]));
        check_ice(mice, wi[7:0]);
    endtask

    task automatic run_frame();
        frame_i = 1'b1;
        @(negedge clk);
        frame_i = 1'b0;
        repeat (3) @(negedge clk);
        model_frame();
    endtask

    initial begin
        logic [15:0] rd;
        int          r;
        frame_i  = 1'b0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = 3'd0;
        wb_dat_i = 8'd0;
        mkeys    = 3'd0;
        model_reset();
        wait (rst_n_i === 1'b1);
        @(negedge clk);
        check_all();

        // unmapped addresses read as zero
        for (int a = 5; a < 8; a++) begin
            wb_access(1'b0, 3'(a), 8'h00, rd);
            if (rd !== 16'h0000) begin
                $display("MISMATCH t=%0t address %0d read %h expected 0", $time, a, rd);
                stop_run("unmapped address returned data");
            end
        end

        for (int f = 0; f < N_FRAMES; f++) begin
            if (f == N_FRAMES / 2) begin
                write_keys(4'b1000);
                check_all();
            end else begin
                r = $random(seed);
                // right wins over left in the key decode, so the walk drifts right
                if (r[1:0] == 2'b00) begin
                    write_keys({r[13:8] == 6'd0, r[6:4]});
                end
            end
            run_frame();
            check_all();
        end

        write_keys(4'b1000);
        check_all();

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+source
source/game_pkg.sv
source/wb_regs.sv
source/block_collide.sv
source/player_motion.sv
source/pickup_tracker.sv
source/stage_fsm.sv
source/game_top.sv
bench/clk_gen.sv
bench/tb_game.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module tb_game -o tb_game_sim

# exit status of the simulation is judged by the log below
./obj_dir/tb_game_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
    exit 1
fi
if ! grep -q "ALL CHECKS PASSED" sim.log; then
    exit 1
fi
exit 0
